//--- verilog/mips_pkg.sv
package mips_pkg;

   /////////////////////////////////////////////////////////////////////////////
   // Register file and datapath sizes.
   /////////////////////////////////////////////////////////////////////////////

   // Architectural registers.
   localparam int CANT_REGISTROS      = 32;
   // Data word width.
   localparam int CANT_BITS_REGISTROS = 32;
   // Register index width.
   localparam int ANCHO_REG           = $clog2(CANT_REGISTROS);

   // Data memory depth, in 32-bit words.
   localparam int PROFUNDIDAD_MEM     = 64;
   // Word address width into the data memory.
   localparam int ANCHO_MEM           = $clog2(PROFUNDIDAD_MEM);

   // APB byte address width.
   localparam int ANCHO_APB           = 8;

   /////////////////////////////////////////////////////////////////////////////
   // Vector types.
   /////////////////////////////////////////////////////////////////////////////

   typedef logic [CANT_BITS_REGISTROS-1:0] dato_t;
   typedef logic [ANCHO_REG-1:0]           reg_addr_t;
   typedef logic [1:0]                     mem_size_t;
   // Register n sits at byte address 4n.
   typedef logic [ANCHO_APB-1:0]           apb_addr_t;

   // Access size codes of loads and stores.
   localparam mem_size_t SIZE_BYTE = 2'd0;
   localparam mem_size_t SIZE_HALF = 2'd1;
   localparam mem_size_t SIZE_WORD = 2'd2;

endpackage

//--- verilog/mem_wb_if.sv
`timescale 1ns/1ns

interface mem_wb_if;

   import mips_pkg::*;

   // Extended load value.
   dato_t     data_mem;
   // ALU result passed along.
   dato_t     data_alu;
   // Destination register of the instruction.
   reg_addr_t registro_destino;

   // Control bits of the latch.
   logic      RegWrite;
   logic      MemtoReg;
   logic      halt_detected;
   // Pipeline enable, for gating in write-back.
   logic      enable_pipeline;

   // Memory stage side, fills the latch.
   modport etapa (
      output data_mem, data_alu, registro_destino,
      output RegWrite, MemtoReg, halt_detected, enable_pipeline
   );

   // Write-back side, reads the latch.
   modport write_back (
      input data_mem, data_alu, registro_destino,
      input RegWrite, MemtoReg, halt_detected, enable_pipeline
   );

endinterface

//--- verilog/etapa_memoria.sv
`timescale 1ns/1ns

module etapa_memoria (
   input  logic                i_clock,
   input  logic                i_soft_reset,
   input  logic                i_enable_pipeline,
   input  mips_pkg::dato_t     i_data_alu,
   input  mips_pkg::dato_t     i_data_store,
   input  mips_pkg::reg_addr_t i_registro_destino,
   input  logic                i_MemRead,
   input  logic                i_MemWrite,
   input  logic                i_RegWrite,
   input  logic                i_MemtoReg,
   input  logic                i_halt_detected,
   input  logic                i_unsigned,
   input  mips_pkg::mem_size_t i_mem_size,
   mem_wb_if.etapa             o_mem_wb
);

   import mips_pkg::*;

   // Data memory, one word per entry.
   dato_t                memoria [PROFUNDIDAD_MEM];

   logic [ANCHO_MEM-1:0] dir_palabra;
   logic [1:0]           offset;
   logic [3:0]           carriles;
   dato_t                dato_alineado;
   dato_t                palabra_leida;
   logic [7:0]           byte_leido;
   logic [15:0]          half_leido;
   dato_t                dato_carga;

   // Word index and byte offset from the ALU result.
   assign dir_palabra = i_data_alu[ANCHO_MEM+1:2];
   assign offset      = i_data_alu[1:0];

   /////////////////////////////////////////////////////////////////////////////
   // Store path.
   /////////////////////////////////////////////////////////////////////////////

   // Byte lanes and store data replicated onto every lane.
   always_comb begin
      case (i_mem_size)
         SIZE_BYTE: begin
            carriles      = 4'b0001 << offset;
            dato_alineado = {4{i_data_store[7:0]}};
         end
         SIZE_HALF: begin
            carriles      = offset[1] ? 4'b1100 : 4'b0011;
            dato_alineado = {2{i_data_store[15:0]}};
         end
         default: begin
            carriles      = 4'b1111;
            dato_alineado = i_data_store;
         end
      endcase
   end

   // Only the selected lanes change.
   always_ff @(posedge i_clock) begin
      if (i_enable_pipeline && i_MemWrite) begin
         for (int b = 0; b < 4; b++) begin
            if (carriles[b])
               memoria[dir_palabra][8*b +: 8] <= dato_alineado[8*b +: 8];
         end
      end
   end

   /////////////////////////////////////////////////////////////////////////////
   // Load path.
   /////////////////////////////////////////////////////////////////////////////

   assign palabra_leida = memoria[dir_palabra];
   // Lane picked by the low address bits.
   assign byte_leido    = palabra_leida[{offset, 3'b000} +: 8];
   assign half_leido    = offset[1] ? palabra_leida[31:16] : palabra_leida[15:0];

   // Sign or zero extension.
   always_comb begin
      case (i_mem_size)
         SIZE_BYTE:
            dato_carga = i_unsigned ? {24'b0, byte_leido}
                                    : {{24{byte_leido[7]}}, byte_leido};
         SIZE_HALF:
            dato_carga = i_unsigned ? {16'b0, half_leido}
                                    : {{16{half_leido[15]}}, half_leido};
         default:
            dato_carga = palabra_leida;
      endcase
   end

   /////////////////////////////////////////////////////////////////////////////
   // MEM/WB latch.
   /////////////////////////////////////////////////////////////////////////////

   // Control bits.
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         o_mem_wb.RegWrite      <= 1'b0;
         o_mem_wb.MemtoReg      <= 1'b0;
         o_mem_wb.halt_detected <= 1'b0;
      end else if (i_enable_pipeline) begin
         o_mem_wb.RegWrite      <= i_RegWrite;
         o_mem_wb.MemtoReg      <= i_MemtoReg;
         o_mem_wb.halt_detected <= i_halt_detected;
      end
   end

   // Payload.
   always_ff @(posedge i_clock) begin
      if (i_enable_pipeline) begin
         o_mem_wb.data_mem         <= i_MemRead ? dato_carga : '0;
         o_mem_wb.data_alu         <= i_data_alu;
         o_mem_wb.registro_destino <= i_registro_destino;
      end
   end

   // Enable travels along for write-back gating.
   assign o_mem_wb.enable_pipeline = i_enable_pipeline;

   // A memory access is either a load or a store.
   a_read_write_excl: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      i_enable_pipeline |-> !(i_MemRead && i_MemWrite));

   // Halfword and word accesses are naturally aligned.
   a_alineado: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      (i_enable_pipeline && (i_MemRead || i_MemWrite)) |->
         ((i_mem_size != SIZE_HALF || !offset[0]) &&
          (i_mem_size != SIZE_WORD || offset == 2'b00)));

endmodule

//--- verilog/top_write_back.sv
`timescale 1ns/1ns

module top_write_back (
   input  logic                i_clock,
   input  logic                i_soft_reset,
   mem_wb_if.write_back        i_mem_wb,
   output mips_pkg::reg_addr_t o_registro_destino,
   output logic                o_RegWrite,
   output mips_pkg::dato_t     o_data_write,
   output logic                o_halt_detected,
   output logic                o_led
);

   /////////////////////////////////////////////////////////////////////////////
   // Write data selection.
   /////////////////////////////////////////////////////////////////////////////

   // Load value for loads, else the ALU result.
   assign o_data_write = i_mem_wb.MemtoReg ? i_mem_wb.data_mem : i_mem_wb.data_alu;

   // Destination goes straight to the register file.
   assign o_registro_destino = i_mem_wb.registro_destino;

   // Write only on an enabled edge, once per instruction.
   assign o_RegWrite = i_mem_wb.RegWrite & i_mem_wb.enable_pipeline;

   /////////////////////////////////////////////////////////////////////////////
   // Halt latch.
   /////////////////////////////////////////////////////////////////////////////

   // Sticky until reset.
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         o_halt_detected <= 1'b0;
      end else if (i_mem_wb.enable_pipeline && i_mem_wb.halt_detected) begin
         o_halt_detected <= 1'b1;
      end
   end

   // Board LED shows the halt.
   assign o_led = o_halt_detected;

   // Once halted, the pipeline stays halted.
   a_halt_sticky: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      o_halt_detected |=> o_halt_detected);

endmodule

//--- verilog/banco_registros.sv
`timescale 1ns/1ns

module banco_registros (
   input  logic                i_clock,
   input  logic                i_soft_reset,
   input  mips_pkg::reg_addr_t i_registro_destino,
   input  mips_pkg::dato_t     i_data_write,
   input  logic                i_RegWrite,
   input  logic                i_psel,
   input  logic                i_penable,
   input  logic                i_pwrite,
   input  mips_pkg::apb_addr_t i_paddr,
   output mips_pkg::dato_t     o_prdata,
   output logic                o_pready,
   output logic                o_pslverr
);

   import mips_pkg::*;

   // Architectural registers.
   dato_t     registros [CANT_REGISTROS];

   logic      fase_acceso;
   reg_addr_t indice_apb;
   logic      desalineado;

   /////////////////////////////////////////////////////////////////////////////
   // Write port from write-back.
   /////////////////////////////////////////////////////////////////////////////

   // Register 0 is hardwired to zero.
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         for (int r = 0; r < CANT_REGISTROS; r++)
            registros[r] <= '0;
      end else if (i_RegWrite && (i_registro_destino != '0)) begin
         registros[i_registro_destino] <= i_data_write;
      end
   end

   /////////////////////////////////////////////////////////////////////////////
   // APB read slave.
   /////////////////////////////////////////////////////////////////////////////

   // Access phase of a transfer.
   assign fase_acceso = i_psel & i_penable;

   // Register index is the byte address over four.
   assign indice_apb  = i_paddr[ANCHO_REG+1:2];
   assign desalineado = |i_paddr[1:0];

   // No wait states.
   assign o_pready  = fase_acceso;

   // Writes are not supported.
   assign o_pslverr = fase_acceso & (i_pwrite | desalineado);

   // Read data only during the access phase.
   always_comb begin
      if (fase_acceso && !i_pwrite)
         o_prdata = registros[indice_apb];
      else
         o_prdata = '0;
   end

   // Enable is only raised on a selected slave.
   a_penable_psel: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      i_penable |-> i_psel);

endmodule

//--- verilog/top_mips_back_end.sv
`timescale 1ns/1ns

module top_mips_back_end (
   input  logic                i_clock,
   input  logic                i_soft_reset,
   input  logic                i_enable_pipeline,
   // EX/MEM latch values.
   input  mips_pkg::dato_t     i_data_alu,
   input  mips_pkg::dato_t     i_data_store,
   input  mips_pkg::reg_addr_t i_registro_destino,
   input  logic                i_MemRead,
   input  logic                i_MemWrite,
   input  logic                i_RegWrite,
   input  logic                i_MemtoReg,
   input  logic                i_halt_detected,
   input  logic                i_unsigned,
   input  mips_pkg::mem_size_t i_mem_size,
   // Debug APB port.
   input  logic                i_psel,
   input  logic                i_penable,
   input  logic                i_pwrite,
   input  mips_pkg::apb_addr_t i_paddr,
   // Write-back results.
   output mips_pkg::reg_addr_t o_registro_destino,
   output logic                o_RegWrite,
   output mips_pkg::dato_t     o_data_write,
   output logic                o_halt_detected,
   output logic                o_led,
   output mips_pkg::dato_t     o_prdata,
   output logic                o_pready,
   output logic                o_pslverr
);

   // MEM/WB latch between memory and write-back.
   mem_wb_if mem_wb_bus ();

   /////////////////////////////////////////////////////////////////////////////
   // Memory stage.
   /////////////////////////////////////////////////////////////////////////////

   etapa_memoria u_etapa_memoria (
      .i_clock            (i_clock),
      .i_soft_reset       (i_soft_reset),
      .i_enable_pipeline  (i_enable_pipeline),
      .i_data_alu         (i_data_alu),
      .i_data_store       (i_data_store),
      .i_registro_destino (i_registro_destino),
      .i_MemRead          (i_MemRead),
      .i_MemWrite         (i_MemWrite),
      .i_RegWrite         (i_RegWrite),
      .i_MemtoReg         (i_MemtoReg),
      .i_halt_detected    (i_halt_detected),
      .i_unsigned         (i_unsigned),
      .i_mem_size         (i_mem_size),
      .o_mem_wb           (mem_wb_bus.etapa)
   );

   // Write-back stage.
   top_write_back u_top_write_back (
      .i_clock            (i_clock),
      .i_soft_reset       (i_soft_reset),
      .i_mem_wb           (mem_wb_bus.write_back),
      .o_registro_destino (o_registro_destino),
      .o_RegWrite         (o_RegWrite),
      .o_data_write       (o_data_write),
      .o_halt_detected    (o_halt_detected),
      .o_led              (o_led)
   );

   // Register file, written from write-back.
   banco_registros u_banco_registros (
      .i_clock            (i_clock),
      .i_soft_reset       (i_soft_reset),
      .i_registro_destino (o_registro_destino),
      .i_data_write       (o_data_write),
      .i_RegWrite         (o_RegWrite),
      .i_psel             (i_psel),
      .i_penable          (i_penable),
      .i_pwrite           (i_pwrite),
      .i_paddr            (i_paddr),
      .o_prdata           (o_prdata),
      .o_pready           (o_pready),
      .o_pslverr          (o_pslverr)
   );

endmodule

//--- testbench/monitor_back_end.sv
`timescale 1ns/1ns

module monitor_back_end (
   input  logic                i_clock,
   input  logic                i_soft_reset,
   input  logic                i_enable_pipeline,
   input  logic                i_halt_detected,
   // Expected values from the driver.
   input  logic                i_instr_valid,
   input  mips_pkg::dato_t     i_exp_data_write,
   input  mips_pkg::reg_addr_t i_exp_registro_destino,
   input  logic                i_exp_RegWrite,
   input  mips_pkg::dato_t     i_exp_prdata,
   input  logic                i_exp_pslverr,
   // APB controls and DUT outputs.
   input  logic                i_psel,
   input  logic                i_penable,
   input  mips_pkg::reg_addr_t i_registro_destino,
   input  logic                i_RegWrite,
   input  mips_pkg::dato_t     i_data_write,
   input  logic                i_halt_out,
   input  logic                i_led,
   input  mips_pkg::dato_t     i_prdata,
   input  logic                i_pready,
   input  logic                i_pslverr,
   output int                  o_error_count,
   output int                  o_instr_checked
);

   import mips_pkg::*;

   // Instructions waiting for write-back.
   dato_t     data_q [$];
   reg_addr_t dest_q [$];
   logic      we_q   [$];

   // Halt flag in the latch, then in the sticky register.
   logic      halt_latched;
   logic      halt_expected;

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
      if (got !== expected) begin
         $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, expected);
         o_error_count++;
      end
   endtask

   always @(posedge i_clock) begin
      if (!i_soft_reset) begin
         halt_latched  = 1'b0;
         halt_expected = 1'b0;
      end else begin
         compare_value("o_halt_detected", i_halt_out, halt_expected);
         compare_value("o_led", i_led, halt_expected);
         // Outputs belong to the instruction of the previous enabled edge.
         if (i_enable_pipeline) begin
            if (data_q.size() > 0) begin
               compare_value("o_data_write", i_data_write, data_q.pop_front());
               compare_value("o_registro_destino", i_registro_destino, dest_q.pop_front());
               compare_value("o_RegWrite", i_RegWrite, we_q.pop_front());
               o_instr_checked++;
            end
            if (i_instr_valid) begin
               data_q.push_back(i_exp_data_write);
               dest_q.push_back(i_exp_registro_destino);
               we_q.push_back(i_exp_RegWrite);
            end
            halt_expected = halt_expected | halt_latched;
            halt_latched  = i_halt_detected;
         end else begin
            // A stalled edge writes no register.
            compare_value("o_RegWrite", i_RegWrite, 1'b0);
         end
         // Zero wait states.
         // Response only in the access phase.
         if (i_psel && i_penable) begin
            compare_value("o_pready", i_pready, 1'b1);
            compare_value("o_pslverr", i_pslverr, i_exp_pslverr);
            if (!i_exp_pslverr)
               compare_value("o_prdata", i_prdata, i_exp_prdata);
         end else begin
            compare_value("o_pready", i_pready, 1'b0);
            compare_value("o_pslverr", i_pslverr, 1'b0);
         end
      end
   end

endmodule

//--- testbench/tb_top_mips_back_end.sv
`timescale 1ns/1ns

module tb_top_mips_back_end;

   import mips_pkg::*;

   localparam int MAX_LINES      = 64;
   localparam int START_SEED     = 32'h0e47fa23;
   localparam int TIMEOUT_MARGIN = 100;

   logic      clock;
   logic      soft_reset;
   logic      enable_pipeline;
   dato_t     data_alu;
   dato_t     data_store;
   reg_addr_t registro_destino;
   logic      mem_read;
   logic      mem_write;
   logic      reg_write;
   logic      memto_reg;
   logic      halt_in;
   logic      unsigned_load;
   mem_size_t mem_size;
   logic      psel;
   logic      penable;
   logic      pwrite;
   apb_addr_t paddr;

   reg_addr_t wb_registro_destino;
   logic      wb_reg_write;
   dato_t     wb_data_write;
   logic      halt_out;
   logic      led;
   dato_t     prdata;
   logic      pready;
   logic      pslverr;

   // Expected values handed to the monitor.
   logic      instr_valid;
   dato_t     exp_data_write;
   reg_addr_t exp_registro_destino;
   logic      exp_reg_write;
   dato_t     exp_prdata;
   logic      exp_pslverr;

   logic [127:0] records [MAX_LINES];
   integer       seed;
   int           line_count;
   int           instr_count;
   int           cycle_count;
   int           timeout_limit;
   int           tb_errors;
   int           error_count;
   int           instr_checked;

   top_mips_back_end top_mips_back_end_inst (
      .i_clock            (clock),
      .i_soft_reset       (soft_reset),
      .i_enable_pipeline  (enable_pipeline),
      .i_data_alu         (data_alu),
      .i_data_store       (data_store),
      .i_registro_destino (registro_destino),
      .i_MemRead          (mem_read),
      .i_MemWrite         (mem_write),
      .i_RegWrite         (reg_write),
      .i_MemtoReg         (memto_reg),
      .i_halt_detected    (halt_in),
      .i_unsigned         (unsigned_load),
      .i_mem_size         (mem_size),
      .i_psel             (psel),
      .i_penable          (penable),
      .i_pwrite           (pwrite),
      .i_paddr            (paddr),
      .o_registro_destino (wb_registro_destino),
      .o_RegWrite         (wb_reg_write),
      .o_data_write       (wb_data_write),
      .o_halt_detected    (halt_out),
      .o_led              (led),
      .o_prdata           (prdata),
      .o_pready           (pready),
      .o_pslverr          (pslverr)
   );

   monitor_back_end monitor_back_end_inst (
      .i_clock                (clock),
      .i_soft_reset           (soft_reset),
      .i_enable_pipeline      (enable_pipeline),
      .i_halt_detected        (halt_in),
      .i_instr_valid          (instr_valid),
      .i_exp_data_write       (exp_data_write),
      .i_exp_registro_destino (exp_registro_destino),
      .i_exp_RegWrite         (exp_reg_write),
      .i_exp_prdata           (exp_prdata),
      .i_exp_pslverr          (exp_pslverr),
      .i_psel                 (psel),
      .i_penable              (penable),
      .i_registro_destino     (wb_registro_destino),
      .i_RegWrite             (wb_reg_write),
      .i_data_write           (wb_data_write),
      .i_halt_out             (halt_out),
      .i_led                  (led),
      .i_prdata               (prdata),
      .i_pready               (pready),
      .i_pslverr              (pslverr),
      .o_error_count          (error_count),
      .o_instr_checked        (instr_checked)
   );

   // 10 ns clock.
   initial clock = 1'b0;
   always #5 clock = ~clock;

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus tasks.
   ////////////////////////////////////////////////////////////////////////////

   // Empty slot, no memory or register side effects.
   task automatic drive_bubble(input logic enable);
      enable_pipeline  <= enable;
      data_alu         <= '0;
      data_store       <= '0;
      registro_destino <= '0;
      mem_read         <= 1'b0;
      mem_write        <= 1'b0;
      reg_write        <= 1'b0;
      memto_reg        <= 1'b0;
      halt_in          <= 1'b0;
      unsigned_load    <= 1'b0;
      mem_size         <= SIZE_WORD;
      psel             <= 1'b0;
      penable          <= 1'b0;
      pwrite           <= 1'b0;
      paddr            <= '0;
      instr_valid      <= 1'b0;
   endtask

   // Random stall cycles first, then one enabled instruction.
   task automatic run_instruction(input logic [127:0] rec);
      int idle_cycles;
      idle_cycles = 0;
      if (rec[117])
         idle_cycles = $random(seed) & 3;
      repeat (idle_cycles) begin
         @(posedge clock);
         drive_bubble(1'b0);
      end
      @(posedge clock);
      drive_bubble(1'b1);
      mem_read             <= rec[123];
      mem_write            <= rec[122];
      reg_write            <= rec[121];
      memto_reg            <= rec[120];
      halt_in              <= rec[119];
      unsigned_load        <= rec[118];
      mem_size             <= rec[113:112];
      registro_destino     <= rec[108:104];
      data_alu             <= rec[95:64];
      data_store           <= rec[63:32];
      instr_valid          <= 1'b1;
      exp_data_write       <= rec[31:0];
      exp_registro_destino <= rec[100:96];
      exp_reg_write        <= rec[116];
   endtask

   // Setup phase, then access phase.
   task automatic run_apb(input logic [127:0] rec);
      @(posedge clock);
      drive_bubble(1'b1);
      psel        <= 1'b1;
      pwrite      <= rec[120];
      paddr       <= rec[111:104];
      exp_prdata  <= rec[31:0];
      exp_pslverr <= rec[116];
      @(posedge clock);
      penable <= 1'b1;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence.
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      seed          = START_SEED;
      tb_errors     = 0;
      line_count    = 0;
      instr_count   = 0;
      timeout_limit = 0;
      soft_reset   <= 1'b0;
      drive_bubble(1'b0);
      for (int i = 0; i < MAX_LINES; i++)
         records[i] = '0;
      $readmemh("testbench/back_end_input.txt", records);
      // Kind 0 marks the end of the data.
      while (line_count < MAX_LINES && records[line_count][127:124] != 4'h0)
         line_count++;
      timeout_limit = 4 * line_count + TIMEOUT_MARGIN;
      if (line_count == 0) begin
         $display("No transactions were read from the input file.");
         tb_errors++;
      end
      repeat (8) @(posedge clock);
      soft_reset <= 1'b1;
      for (int i = 0; i < line_count; i++) begin
         case (records[i][127:124])
            4'h1: begin
               run_instruction(records[i]);
               instr_count++;
            end
            4'h2: run_apb(records[i]);
            default: begin
               $display("Unknown transaction kind on input line %0d.", i);
               tb_errors++;
            end
         endcase
      end
      // Let the last instruction reach write-back.
      repeat (2) begin
         @(posedge clock);
         drive_bubble(1'b1);
      end
      @(posedge clock);
      if (!halt_out || !led) begin
         $display("The halt flag or the LED is not set at the end of the run.");
         tb_errors++;
      end
      if (instr_checked != instr_count) begin
         $display("%0d instructions driven but %0d written back.", instr_count, instr_checked);
         tb_errors++;
      end
      $display("Instructions checked: %0d of %0d, monitor errors: %0d, testbench errors: %0d",
               instr_checked, instr_count, error_count, tb_errors);
      if (error_count == 0 && tb_errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

   // Run limit from the number of transactions.
   always @(posedge clock) begin
      cycle_count = cycle_count + 1;
      if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
         $display("Timeout after %0d cycles, the stimulus did not complete.", cycle_count);
         $display("Verification failed");
         $finish;
      end
   end

endmodule

//--- testbench/back_end_input.txt
// kind(1=instr,2=apb) _ {MemRead,MemWrite,RegWrite,MemtoReg} or {0,0,0,pwrite} _ {halt,unsigned,stall,expRegWrite} or {0,0,0,pslverr}
// _ size _ rd or paddr _ expected rd _ data_alu _ data_store _ expected data_write or prdata
1_2_3_2_01_01_00000011_00000000_00000011
1_2_3_2_02_02_DEADBEEF_00000000_DEADBEEF
1_2_3_2_03_03_12345678_00000000_12345678
1_2_1_2_04_04_0000ABCD_00000000_0000ABCD
1_2_3_2_1F_1F_80000001_00000000_80000001
1_4_2_2_00_00_00000010_CAFEF00D_00000010
1_B_3_2_05_05_00000010_00000000_CAFEF00D
1_4_2_2_00_00_00000020_11223344_00000020
1_4_2_0_00_00_00000021_123456A5_00000021
1_4_2_1_00_00_00000022_ABCD8001_00000022
1_B_3_0_14_14_00000020_00000000_00000044
1_B_3_0_06_06_00000021_00000000_FFFFFFA5
1_B_7_0_07_07_00000021_00000000_000000A5
1_B_3_1_08_08_00000022_00000000_FFFF8001
1_B_7_1_09_09_00000022_00000000_00008001
1_B_3_1_0A_0A_00000020_00000000_FFFFA544
1_B_3_2_0B_0B_00000020_00000000_8001A544
1_B_7_0_0C_0C_00000023_00000000_00000080
1_B_3_0_0D_0D_00000023_00000000_FFFFFF80
1_2_3_2_00_00_0000BEEF_00000000_0000BEEF
1_0_2_2_01_01_FFFFFFFF_00000000_FFFFFFFF
1_2_3_2_03_03_00000333_00000000_00000333
2_0_0_0_00_00_00000000_00000000_00000000
2_0_0_0_04_00_00000000_00000000_00000011
2_0_0_0_08_00_00000000_00000000_DEADBEEF
2_0_0_0_0C_00_00000000_00000000_00000333
2_0_0_0_10_00_00000000_00000000_0000ABCD
2_0_0_0_14_00_00000000_00000000_CAFEF00D
2_0_0_0_18_00_00000000_00000000_FFFFFFA5
2_0_0_0_1C_00_00000000_00000000_000000A5
2_0_0_0_20_00_00000000_00000000_FFFF8001
2_0_0_0_2C_00_00000000_00000000_8001A544
2_0_0_0_34_00_00000000_00000000_FFFFFF80
2_0_0_0_50_00_00000000_00000000_00000044
2_0_0_0_7C_00_00000000_00000000_80000001
2_1_1_0_08_00_00000000_00000000_00000000
2_0_1_0_05_00_00000000_00000000_00000000
2_0_1_0_0E_00_00000000_00000000_00000000
1_2_B_2_0E_0E_00000E0E_00000000_00000E0E
1_2_3_2_0F_0F_0000F0F0_00000000_0000F0F0
1_2_3_2_10_10_00000010_00000000_00000010
2_0_0_0_38_00_00000000_00000000_00000E0E
2_0_0_0_3C_00_00000000_00000000_0000F0F0
2_0_0_0_40_00_00000000_00000000_00000010

//--- src.f
verilog/mips_pkg.sv
verilog/mem_wb_if.sv
verilog/etapa_memoria.sv
verilog/top_write_back.sv
verilog/banco_registros.sv
verilog/top_mips_back_end.sv
testbench/monitor_back_end.sv
testbench/tb_top_mips_back_end.sv

//--- Bender.yml
package:
  name: mips_back_end

sources:
  - verilog/mips_pkg.sv
  - verilog/mem_wb_if.sv
  - verilog/etapa_memoria.sv
  - verilog/top_write_back.sv
  - verilog/banco_registros.sv
  - verilog/top_mips_back_end.sv
  - target: simulation
    files:
      - testbench/monitor_back_end.sv
      - testbench/tb_top_mips_back_end.sv
